// File: sim.f
+incdir+design
design/conv_data_pkg.sv
design/conv_ctrl_pkg.sv
design/conv_loop_data_in.sv
design/conv_7x7_engine.sv
design/conv_channel_in_adder.sv
design/conv_out_align.sv
design/cnn_conv_7x7.sv
verification/tb_cnn_conv_7x7.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_cnn_conv_7x7

out="$(./obj_dir/Vtb_cnn_conv_7x7)"
echo "$out"

if echo "$out" | grep -Fqx ">>> PASS"; then
	exit 0
fi
exit 1

// File: verification/tb_cnn_conv_7x7.sv
`include "conv_defines.svh"

module tb_cnn_conv_7x7;

	localparam int KK        = `CONV_KERNEL * `CONV_KERNEL;
	localparam int HALF      = `CONV_KERNEL / 2;
	localparam int N_FRAMES  = 3;
	localparam int TOTAL_OUT = N_FRAMES * `CONV_FRAME_OUT_SIZE;
	// Per frame: weights, pixels, four replayed planes with gaps, release
	localparam int TIMEOUT_CYCLES = N_FRAMES * (`CONV_WEIGHT_NUM + `CONV_FRAME_IN_SIZE +
		4 * (`CONV_PLANE_SIZE + `CONV_PLANE_GAP) + `CONV_FRAME_OUT_SIZE) + 1000;

	logic                  clk;
	logic                  reset;
	logic                  valid_in;
	conv_data_pkg::pixel_t pxl_in;
	logic                  valid_weight_in;
	conv_data_pkg::pixel_t weight_in;
	conv_data_pkg::pixel_t pxl_out;
	logic                  valid_out;

	////////////////////////////////////////
	// Stimulus table
	// Kernel mode 0 centre tap, 1 corner tap, 2 random
	// Pixel mode 0 small random, 1 full-range random (exercises 16-bit wrap)
	string test_name   [N_FRAMES] = '{"identity_kernel", "zero_padding", "random_frame"};
	int    kernel_mode [N_FRAMES] = '{0, 1, 2};
	int    pixel_mode  [N_FRAMES] = '{1, 1, 0};

	conv_data_pkg::pixel_t wt      [N_FRAMES][`CONV_WEIGHT_NUM];
	conv_data_pkg::pixel_t px      [N_FRAMES][`CONV_FRAME_IN_SIZE];
	conv_data_pkg::pixel_t exp_val [N_FRAMES][`CONV_FRAME_OUT_SIZE];

	int   seed       = 32'hd4dcb50f;
	int   cycle_cnt  = 0;
	int   out_cnt    = 0;
	int   first_runs = 0;
	int   value_err  = 0;
	int   timeout_err = 0;
	logic prev_valid = 1'b0;
	logic stop_req   = 1'b0;

	cnn_conv_7x7 UUT (
		.clk            (clk),
		.reset          (reset),
		.valid_in       (valid_in),
		.pxl_in         (pxl_in),
		.valid_weight_in(valid_weight_in),
		.weight_in      (weight_in),
		.pxl_out        (pxl_out),
		.valid_out      (valid_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			value_err = value_err + 1;
			$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// Weights ordered oc, ic, ky, kx; pixels ic then raster
	task automatic make_stimulus(input int f);
		int k;
		for (k = 0; k < `CONV_WEIGHT_NUM; k++) begin
			case (kernel_mode[f])
				0: wt[f][k] = (k % KK == HALF * `CONV_KERNEL + HALF) ? 16'sd256 : 16'sd0;
				1: wt[f][k] = (k % KK == 0) ? 16'sd256 : 16'sd0;
				// Within +-1.0
				default: wt[f][k] = conv_data_pkg::pixel_t'(($random(seed) & 32'h1ff) - 256);
			endcase
		end
		for (k = 0; k < `CONV_FRAME_IN_SIZE; k++) begin
			if (pixel_mode[f] == 0) begin
				// Within +-2.0, keeps 49-tap sums exact
				px[f][k] = conv_data_pkg::pixel_t'(($random(seed) & 32'h3ff) - 512);
			end else begin
				px[f][k] = conv_data_pkg::pixel_t'($random(seed));
			end
		end
	endtask

	////////////////////////////////////////
	// Reference model
	task automatic build_expected(input int f);
		int oc;
		int ic;
		int p;
		int ky;
		int kx;
		int sr;
		int sc;
		int acc;
		conv_data_pkg::pixel_t conv;
		conv_data_pkg::pixel_t sum;
		for (oc = 0; oc < `CONV_CH_OUT; oc++) begin
			for (p = 0; p < `CONV_PLANE_SIZE; p++) begin
				// Channel sum wraps at 16 bits
				sum = '0;
				for (ic = 0; ic < `CONV_CH_IN; ic++) begin
					acc = 0;
					for (ky = 0; ky < `CONV_KERNEL; ky++) begin
						for (kx = 0; kx < `CONV_KERNEL; kx++) begin
							sr = p / `CONV_IMAGE_WIDTH + ky - HALF;
							sc = p % `CONV_IMAGE_WIDTH + kx - HALF;
							// Outside the image contributes zero
							if (sr >= 0 && sr < `CONV_IMAGE_HEIGHT &&
								sc >= 0 && sc < `CONV_IMAGE_WIDTH) begin
								acc = acc + int'(px[f][ic * `CONV_PLANE_SIZE +
									sr * `CONV_IMAGE_WIDTH + sc]) *
									int'(wt[f][(oc * `CONV_CH_IN + ic) * KK +
									ky * `CONV_KERNEL + kx]);
							end
						end
					end
					// Back to Q8.8, low 16 bits
					conv = conv_data_pkg::pixel_t'(acc >>> `CONV_FRAC_BITS);
					sum  = sum + conv;
				end
				exp_val[f][oc * `CONV_PLANE_SIZE + p] = sum;
			end
		end
	endtask

	task automatic drive_weights(input int f);
		int k;
		for (k = 0; k < `CONV_WEIGHT_NUM; k++) begin
			@(posedge clk);
			valid_weight_in <= 1'b1;
			weight_in       <= wt[f][k];
		end
		@(posedge clk);
		valid_weight_in <= 1'b0;
	endtask

	task automatic drive_pixels(input int f);
		int k;
		for (k = 0; k < `CONV_FRAME_IN_SIZE; k++) begin
			@(posedge clk);
			valid_in <= 1'b1;
			pxl_in   <= px[f][k];
		end
		@(posedge clk);
		valid_in <= 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence
	initial begin
		reset           = 1'b1;
		valid_in        = 1'b0;
		pxl_in          = '0;
		valid_weight_in = 1'b0;
		weight_in       = '0;
		for (int f = 0; f < N_FRAMES; f++) begin
			make_stimulus(f);
			build_expected(f);
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// Frames back to back, no reset, fresh weights each time
		for (int f = 0; f < N_FRAMES; f++) begin
			drive_weights(f);
			drive_pixels(f);
			while (out_cnt < (f + 1) * `CONV_FRAME_OUT_SIZE) begin
				@(posedge clk);
			end
		end
		// Room for any stray strobe
		repeat (200) @(posedge clk);
		stop_req <= 1'b1;
	end

	////////////////////////////////////////
	// Output monitor, checks and end of run
	always @(negedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (reset) begin
			check_value("quiet during reset", 0, int'(valid_out));
		end
		if (valid_out && !reset) begin
			if (out_cnt < TOTAL_OUT) begin
				check_value($sformatf("%s[%0d]", test_name[out_cnt / `CONV_FRAME_OUT_SIZE],
					out_cnt % `CONV_FRAME_OUT_SIZE),
					int'(exp_val[out_cnt / `CONV_FRAME_OUT_SIZE][out_cnt % `CONV_FRAME_OUT_SIZE]),
					int'(pxl_out));
			end
			// First frame must come out as one unbroken run
			if (!prev_valid && out_cnt < `CONV_FRAME_OUT_SIZE) begin
				first_runs = first_runs + 1;
			end
			out_cnt = out_cnt + 1;
		end
		prev_valid = valid_out;
		if (stop_req || cycle_cnt >= TIMEOUT_CYCLES) begin
			if (stop_req) begin
				check_value("output strobe count", TOTAL_OUT, out_cnt);
				check_value("first frame strobe runs", 1, first_runs);
			end else begin
				timeout_err = timeout_err + 1;
				$display("timeout, outputs missing");
			end
			$display("errors: value=%0d timeout=%0d outputs=%0d", value_err, timeout_err, out_cnt);
			if (value_err == 0 && timeout_err == 0) begin
				$display(">>> PASS");
			end else begin
				$display(">>> FAIL");
			end
			$finish;
		end
	end

endmodule

// File: design/cnn_conv_7x7.sv
module cnn_conv_7x7 (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pxl_in,
	input  logic                  valid_weight_in,
	input  conv_data_pkg::pixel_t weight_in,
	output conv_data_pkg::pixel_t pxl_out,
	output logic                  valid_out
);

	// Replayed planes
	conv_data_pkg::pixel_t loop_pxl;
	logic                  loop_valid;
	// Per-plane convolution results
	conv_data_pkg::pixel_t conv_pxl;
	logic                  conv_valid;
	// Channel-summed output maps
	conv_data_pkg::pixel_t add_pxl;
	logic                  add_valid;

	conv_loop_data_in inst_loop (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pxl_in   (pxl_in),
		.pxl_out  (loop_pxl),
		.valid_out(loop_valid)
	);

	conv_7x7_engine inst_conv (
		.clk            (clk),
		.reset          (reset),
		.valid_in       (loop_valid),
		.pxl_in         (loop_pxl),
		.valid_weight_in(valid_weight_in),
		.weight_in      (weight_in),
		.pxl_out        (conv_pxl),
		.valid_out      (conv_valid)
	);

	conv_channel_in_adder inst_add (
		.clk      (clk),
		.reset    (reset),
		.valid_in (conv_valid),
		.pxl_in   (conv_pxl),
		.pxl_out  (add_pxl),
		.valid_out(add_valid)
	);

	// Holds the first frame until complete
	conv_out_align inst_align (
		.clk      (clk),
		.reset    (reset),
		.valid_in (add_valid),
		.pxl_in   (add_pxl),
		.pxl_out  (pxl_out),
		.valid_out(valid_out)
	);

endmodule

// File: design/conv_out_align.sv
`include "conv_defines.svh"

module conv_out_align (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pxl_in,
	output conv_data_pkg::pixel_t pxl_out,
	output logic                  valid_out
);

	localparam int DEPTH = `CONV_FRAME_OUT_SIZE;
	localparam int PTR_W = $clog2(DEPTH);

	conv_data_pkg::pixel_t buf_mem [DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [PTR_W:0]        count;
	logic                  release_flag;
	logic                  full;
	logic                  empty;
	logic                  wr_en;
	logic                  rd_en;

	assign full  = (count == (PTR_W + 1)'(DEPTH));
	assign empty = (count == '0);
	assign rd_en = release_flag && !empty;
	// Drop writes only on a true overflow
	assign wr_en = valid_in && (!full || rd_en);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			buf_mem[wr_ptr] <= pxl_in;
		end
		if (rd_en) begin
			pxl_out <= buf_mem[rd_ptr];
		end
	end

	////////////////////////////////////////
	// Pointers, occupancy, release
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			release_flag <= 1'b0;
			valid_out    <= 1'b0;
		end else begin
			// Pointers wrap at power-of-two depth
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky once the first frame is complete
			if (full) begin
				release_flag <= 1'b1;
			end
			valid_out <= rd_en;
		end
	end

endmodule

// File: design/conv_channel_in_adder.sv
`include "conv_defines.svh"

module conv_channel_in_adder (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pxl_in,
	output conv_data_pkg::pixel_t pxl_out,
	output logic                  valid_out
);

	localparam int PADDR_W = $clog2(`CONV_PLANE_SIZE);
	localparam int IC_W    = $clog2(`CONV_CH_IN);

	conv_data_pkg::pixel_t     psum_mem [`CONV_PLANE_SIZE];
	conv_data_pkg::pixel_t     psum_rd;
	conv_ctrl_pkg::plane_cnt_t pix_cnt;
	logic [IC_W-1:0]           ic_cnt;
	logic                      first_pass;
	logic                      last_pass;

	assign first_pass = (ic_cnt == '0);
	assign last_pass  = (ic_cnt == IC_W'(`CONV_CH_IN - 1));
	assign psum_rd    = psum_mem[PADDR_W'(pix_cnt)];

	// Partial sums, wrapping at 16 bits
	always_ff @(posedge clk) begin
		if (valid_in) begin
			if (first_pass) begin
				psum_mem[PADDR_W'(pix_cnt)] <= pxl_in;
			end else if (!last_pass) begin
				psum_mem[PADDR_W'(pix_cnt)] <= psum_rd + pxl_in;
			end
			// Last input channel completes the output pixel
			if (last_pass) begin
				pxl_out <= psum_rd + pxl_in;
			end
		end
	end

	////////////////////////////////////////
	// Pixel and channel counters
	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt   <= '0;
			ic_cnt    <= '0;
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in && last_pass;
			if (valid_in) begin
				if (pix_cnt == conv_ctrl_pkg::plane_cnt_t'(`CONV_PLANE_SIZE - 1)) begin
					pix_cnt <= '0;
					ic_cnt  <= last_pass ? '0 : ic_cnt + 1'b1;
				end else begin
					pix_cnt <= pix_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: design/conv_7x7_engine.sv
`include "conv_defines.svh"

module conv_7x7_engine (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pxl_in,
	input  logic                  valid_weight_in,
	input  conv_data_pkg::pixel_t weight_in,
	output conv_data_pkg::pixel_t pxl_out,
	output logic                  valid_out
);

	localparam int KK      = `CONV_KERNEL * `CONV_KERNEL;
	localparam int HALF    = `CONV_KERNEL / 2;
	localparam int PASS_N  = `CONV_CH_IN * `CONV_CH_OUT;
	localparam int PASS_W  = $clog2(PASS_N);
	localparam int TAP_W   = $clog2(`CONV_KERNEL);
	localparam int PADDR_W = $clog2(`CONV_PLANE_SIZE);
	localparam int WADDR_W = $clog2(`CONV_WEIGHT_NUM);

	conv_data_pkg::pixel_t        weight_mem [`CONV_WEIGHT_NUM];
	conv_data_pkg::pixel_t        plane_mem [`CONV_PLANE_SIZE];
	conv_ctrl_pkg::engine_state_t state;
	conv_ctrl_pkg::plane_cnt_t    ld_cnt;
	conv_ctrl_pkg::plane_cnt_t    out_pos;
	logic [WADDR_W-1:0]           w_ptr;
	logic [WADDR_W-1:0]           w_addr;
	logic [PASS_W-1:0]            pass;
	logic [TAP_W-1:0]             tap_y;
	logic [TAP_W-1:0]             tap_x;
	int                           src_row;
	int                           src_col;
	logic                         tap_ok;
	conv_data_pkg::pixel_t        tap_pxl;
	conv_data_pkg::acc_t          prod;
	conv_data_pkg::acc_t          acc;

	////////////////////////////////////////
	// Tap address and product

	// Source pixel for this tap, centred on the output position
	assign src_row = int'(out_pos) / `CONV_IMAGE_WIDTH + int'(tap_y) - HALF;
	assign src_col = int'(out_pos) % `CONV_IMAGE_WIDTH + int'(tap_x) - HALF;
	assign tap_ok  = (src_row >= 0) && (src_row < `CONV_IMAGE_HEIGHT) &&
		(src_col >= 0) && (src_col < `CONV_IMAGE_WIDTH);

	// Zero padding outside the image
	assign tap_pxl = tap_ok ? plane_mem[PADDR_W'(src_row * `CONV_IMAGE_WIDTH + src_col)] : '0;

	// Weight set picked by pass, then ky, kx
	assign w_addr = WADDR_W'(int'(pass) * KK + int'(tap_y) * `CONV_KERNEL + int'(tap_x));

	// Exact signed 16x16 product
	assign prod = conv_data_pkg::acc_t'(tap_pxl) * conv_data_pkg::acc_t'(weight_mem[w_addr]);

	// Weight and plane storage
	always_ff @(posedge clk) begin
		if (valid_weight_in) begin
			weight_mem[w_ptr] <= weight_in;
		end
		if (state == conv_ctrl_pkg::LOAD && valid_in) begin
			plane_mem[PADDR_W'(ld_cnt)] <= pxl_in;
		end
	end

	// Accumulate, first tap restarts the sum
	always_ff @(posedge clk) begin
		if (state == conv_ctrl_pkg::MAC) begin
			if (tap_y == '0 && tap_x == '0) begin
				acc <= prod;
			end else begin
				acc <= acc + prod;
			end
		end
		if (state == conv_ctrl_pkg::EMIT) begin
			// Back to Q8.8, keep low 16 bits
			pxl_out <= conv_data_pkg::pixel_t'(acc >>> `CONV_FRAC_BITS);
		end
	end

	////////////////////////////////////////
	// Control
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= conv_ctrl_pkg::LOAD;
			w_ptr     <= '0;
			ld_cnt    <= '0;
			out_pos   <= '0;
			pass      <= '0;
			tap_y     <= '0;
			tap_x     <= '0;
			valid_out <= 1'b0;
		end else begin
			valid_out <= 1'b0;
			// Weight pointer wraps so a reload overwrites in order
			if (valid_weight_in) begin
				if (w_ptr == WADDR_W'(`CONV_WEIGHT_NUM - 1)) begin
					w_ptr <= '0;
				end else begin
					w_ptr <= w_ptr + 1'b1;
				end
			end
			case (state)
				conv_ctrl_pkg::LOAD: begin
					if (valid_in) begin
						if (ld_cnt == conv_ctrl_pkg::plane_cnt_t'(`CONV_PLANE_SIZE - 1)) begin
							ld_cnt <= '0;
							state  <= conv_ctrl_pkg::MAC;
						end else begin
							ld_cnt <= ld_cnt + 1'b1;
						end
					end
				end
				conv_ctrl_pkg::MAC: begin
					// kx inner, ky outer
					if (tap_x == TAP_W'(`CONV_KERNEL - 1)) begin
						tap_x <= '0;
						if (tap_y == TAP_W'(`CONV_KERNEL - 1)) begin
							tap_y <= '0;
							state <= conv_ctrl_pkg::EMIT;
						end else begin
							tap_y <= tap_y + 1'b1;
						end
					end else begin
						tap_x <= tap_x + 1'b1;
					end
				end
				conv_ctrl_pkg::EMIT: begin
					valid_out <= 1'b1;
					if (out_pos == conv_ctrl_pkg::plane_cnt_t'(`CONV_PLANE_SIZE - 1)) begin
						out_pos <= '0;
						state   <= conv_ctrl_pkg::LOAD;
						pass    <= (pass == PASS_W'(PASS_N - 1)) ? '0 : pass + 1'b1;
					end else begin
						out_pos <= out_pos + 1'b1;
						state   <= conv_ctrl_pkg::MAC;
					end
				end
				default: state <= conv_ctrl_pkg::LOAD;
			endcase
		end
	end

endmodule

// File: design/conv_loop_data_in.sv
`include "conv_defines.svh"

module conv_loop_data_in (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pxl_in,
	output conv_data_pkg::pixel_t pxl_out,
	output logic                  valid_out
);

	localparam int PLANE_NUM = `CONV_CH_IN * `CONV_CH_OUT;
	localparam int ADDR_W    = $clog2(`CONV_FRAME_IN_SIZE);
	localparam int PLANE_W   = $clog2(PLANE_NUM);
	localparam int GAP_W     = $clog2(`CONV_PLANE_GAP);

	conv_data_pkg::pixel_t      frame_mem [`CONV_FRAME_IN_SIZE];
	conv_ctrl_pkg::loop_state_t state;
	conv_ctrl_pkg::plane_cnt_t  wr_cnt;
	conv_ctrl_pkg::plane_cnt_t  rd_cnt;
	logic [PLANE_W-1:0]         plane_idx;
	logic [GAP_W-1:0]           gap_cnt;
	logic [ADDR_W-1:0]          rd_addr;
	logic                       fill_done;
	logic                       emit;

	// Last pixel of the frame starts replay in the same cycle
	assign fill_done = (state == conv_ctrl_pkg::FILL) && valid_in &&
		(wr_cnt == conv_ctrl_pkg::plane_cnt_t'(`CONV_FRAME_IN_SIZE - 1));
	assign emit = fill_done || (state == conv_ctrl_pkg::REPLAY);

	// Plane order is (oc, ic), so input channel is plane index mod CH_IN
	assign rd_addr = ADDR_W'((int'(plane_idx) % `CONV_CH_IN) * `CONV_PLANE_SIZE +
		int'(rd_cnt));

	// Frame store and replay read
	always_ff @(posedge clk) begin
		if (state == conv_ctrl_pkg::FILL && valid_in) begin
			frame_mem[wr_cnt] <= pxl_in;
		end
		if (emit) begin
			pxl_out <= frame_mem[rd_addr];
		end
	end

	////////////////////////////////////////
	// Sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= conv_ctrl_pkg::FILL;
			wr_cnt    <= '0;
			rd_cnt    <= '0;
			plane_idx <= '0;
			gap_cnt   <= '0;
			valid_out <= 1'b0;
		end else begin
			valid_out <= emit;
			case (state)
				conv_ctrl_pkg::FILL: begin
					if (fill_done) begin
						// First replay word already read this cycle
						wr_cnt <= '0;
						rd_cnt <= conv_ctrl_pkg::plane_cnt_t'(1);
						state  <= conv_ctrl_pkg::REPLAY;
					end else if (valid_in) begin
						wr_cnt <= wr_cnt + 1'b1;
					end
				end
				conv_ctrl_pkg::REPLAY: begin
					if (rd_cnt == conv_ctrl_pkg::plane_cnt_t'(`CONV_PLANE_SIZE - 1)) begin
						rd_cnt <= '0;
						state  <= conv_ctrl_pkg::GAP;
					end else begin
						rd_cnt <= rd_cnt + 1'b1;
					end
				end
				conv_ctrl_pkg::GAP: begin
					// Let the engine drain the plane before the next one
					if (gap_cnt == GAP_W'(`CONV_PLANE_GAP - 1)) begin
						gap_cnt <= '0;
						if (plane_idx == PLANE_W'(PLANE_NUM - 1)) begin
							plane_idx <= '0;
							state     <= conv_ctrl_pkg::FILL;
						end else begin
							plane_idx <= plane_idx + 1'b1;
							state     <= conv_ctrl_pkg::REPLAY;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= conv_ctrl_pkg::FILL;
			endcase
		end
	end

endmodule

// File: design/conv_ctrl_pkg.sv
`include "conv_defines.svh"

package conv_ctrl_pkg;

	////////////////////////////////////////
	// State machines

	// Engine: collect a plane, step taps, emit one result
	typedef enum logic [1:0] {
		LOAD,
		MAC,
		EMIT
	} engine_state_t;

	// Loop stage: store frame, replay planes, idle between planes
	typedef enum logic [1:0] {
		FILL,
		REPLAY,
		GAP
	} loop_state_t;

	// Counter sized for a whole input frame
	typedef logic [$clog2(`CONV_FRAME_IN_SIZE)-1:0] plane_cnt_t;

endpackage

// File: design/conv_data_pkg.sv
`include "conv_defines.svh"

package conv_data_pkg;

	////////////////////////////////////////
	// Datapath words

	// Pixel, weight and result word
	// Signed Q8.8
	typedef logic signed [`CONV_DATA_WIDTH-1:0] pixel_t;

	// Full-precision product or running sum
	// Wide enough for 49 exact products of the test ranges
	typedef logic signed [2*`CONV_DATA_WIDTH-1:0] acc_t;

endpackage

// File: design/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

////////////////////////////////////////
// Data format
// Q8.8 signed words
`define CONV_DATA_WIDTH      16
`define CONV_FRAC_BITS       8

////////////////////////////////////////
// Geometry
`define CONV_IMAGE_WIDTH     8
`define CONV_IMAGE_HEIGHT    8
`define CONV_CH_IN           2
`define CONV_CH_OUT          2
`define CONV_KERNEL          7

// Buffer depths
`define CONV_PLANE_SIZE      64
`define CONV_FRAME_IN_SIZE   128
`define CONV_FRAME_OUT_SIZE  128
// Weights for every (out, in) channel pair
`define CONV_WEIGHT_NUM      196

// Idle cycles after a replayed plane, engine needs 64 x 50 plus margin
`define CONV_PLANE_GAP       3300

`endif
